//--- source/aplic_consts.svh
// Register map offsets, field positions and reset values of the APLIC domain control
`ifndef APLIC_CONSTS_SVH
`define APLIC_CONSTS_SVH

// Sources 1 to 31 plus the unused source 0
`define APLIC_NR_SRC           32
`define APLIC_ADDR_W           14

// ====================================================================
// Register offsets inside the 16 KiB window
// ====================================================================
`define APLIC_DOMAINCFG        14'h0000
`define APLIC_SOURCECFG        14'h0004
`define APLIC_SETIP            14'h1C00
`define APLIC_SETIPNUM         14'h1CDC
`define APLIC_IN_CLRIP         14'h1D00
`define APLIC_CLRIPNUM         14'h1DDC
`define APLIC_SETIE            14'h1E00
`define APLIC_SETIENUM         14'h1EDC
`define APLIC_CLRIE            14'h1F00
`define APLIC_CLRIENUM         14'h1FDC
`define APLIC_TARGET           14'h3004

// domaincfg fields, top byte always reads 0x80
`define APLIC_DOMAINCFG_RESET  32'h8000_0000
`define APLIC_DCFG_IE          8
`define APLIC_DCFG_DM          2
`define APLIC_DCFG_BE          0

// Delegate bit of sourcecfg
`define APLIC_SRC_D            10

`endif

//--- source/aplic_pkg.sv
// Bus, register request and sourcecfg types shared by the APLIC RTL and its testbench
`include "aplic_consts.svh"

package aplic_pkg;

  typedef logic [`APLIC_NR_SRC-1:0] src_vec_t;

  typedef enum logic {
    DOMAIN_M = 1'b0,
    DOMAIN_S = 1'b1
  } domain_e;

  // Wishbone classic, one per configuration master
  typedef struct packed {
    logic                     cyc;
    logic                     stb;
    logic                     we;
    logic [`APLIC_ADDR_W-1:0] adr;
    logic [31:0]              dat;
  } wb_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_rsp_t;

  // One granted access, tagged with the port it came from
  typedef struct packed {
    logic                     valid;
    logic                     we;
    domain_e                  domain;
    logic [`APLIC_ADDR_W-1:0] adr;
    logic [31:0]              dat;
  } reg_req_t;

  typedef struct packed {
    logic       d;
    logic [9:0] child_index;
  } srccfg_dlg_t;

  typedef struct packed {
    logic       d;
    logic [6:0] reserved;
    logic [2:0] sm;
  } srccfg_ndl_t;

  // sourcecfg word, meaning selected by D
  typedef union packed {
    srccfg_dlg_t dlg;
    srccfg_ndl_t ndl;
  } sourcecfg_u;

  // Update applied to one enable or pending vector
  typedef struct packed {
    logic        set_word;
    logic        clr_word;
    logic        set_num;
    logic        clr_num;
    logic [31:0] data;
    logic [4:0]  num;
  } bitvec_op_t;

endpackage

//--- source/aplic_wb_arbiter.sv
// Round-robin arbiter joining the M and S Wishbone classic ports onto one register access
`timescale 1ns/100ps

module aplic_wb_arbiter (
  input  logic                i_clk,
  input  logic                ni_rst,
  input  aplic_pkg::wb_req_t  i_m_wb,
  input  aplic_pkg::wb_req_t  i_s_wb,
  input  logic [31:0]         i_rdata,
  output aplic_pkg::wb_rsp_t  o_m_wb,
  output aplic_pkg::wb_rsp_t  o_s_wb,
  output aplic_pkg::reg_req_t o_req
);
  import aplic_pkg::*;

  logic    valid_q;
  domain_e last_q;
  wb_req_t win_q;
  logic    m_ack;
  logic    s_ack;
  logic    m_req;
  logic    s_req;
  logic    m_gnt;
  logic    s_gnt;

  // Last grant also tags the access in flight
  assign m_ack = valid_q && (last_q == DOMAIN_M);
  assign s_ack = valid_q && (last_q == DOMAIN_S);

  // Hold-off: master still drives stb during its ack cycle
  assign m_req = i_m_wb.cyc && i_m_wb.stb && !m_ack;
  assign s_req = i_s_wb.cyc && i_s_wb.stb && !s_ack;

  // On a tie the port not granted last wins
  assign s_gnt = s_req && (!m_req || (last_q == DOMAIN_M));
  assign m_gnt = m_req && !s_gnt;

  always_ff @(posedge i_clk or negedge ni_rst) begin
    if (!ni_rst) begin
      valid_q <= 1'b0;
      last_q  <= DOMAIN_S;
    end else begin
      valid_q <= m_gnt || s_gnt;
      if (s_gnt) begin
        last_q <= DOMAIN_S;
      end else if (m_gnt) begin
        last_q <= DOMAIN_M;
      end
    end
  end

  // Granted request payload
  always_ff @(posedge i_clk) begin
    if (s_gnt) begin
      win_q <= i_s_wb;
    end else if (m_gnt) begin
      win_q <= i_m_wb;
    end
  end

  always_comb begin
    o_req.valid  = valid_q;
    o_req.we     = win_q.we;
    o_req.domain = last_q;
    o_req.adr    = win_q.adr;
    o_req.dat    = win_q.dat;
  end

  // Read word goes back only to the port being acked
  assign o_m_wb.ack = m_ack;
  assign o_m_wb.dat = m_ack ? i_rdata : '0;
  assign o_s_wb.ack = s_ack;
  assign o_s_wb.dat = s_ack ? i_rdata : '0;

endmodule

//--- source/aplic_bit_vector.sv
// One interrupt enable or pending vector with word and by-number set and clear
`timescale 1ns/100ps

module aplic_bit_vector (
  input  logic                  i_clk,
  input  logic                  ni_rst,
  input  aplic_pkg::bitvec_op_t i_op,
  input  aplic_pkg::src_vec_t   i_active,
  output aplic_pkg::src_vec_t   o_bits
);
  import aplic_pkg::*;

  src_vec_t bits_d;

  always_comb begin
    bits_d = o_bits;
    // One op per cycle, word ops first
    if (i_op.set_word) begin
      bits_d = o_bits | i_op.data;
    end else if (i_op.clr_word) begin
      bits_d = o_bits & ~i_op.data;
    end else if (i_op.set_num) begin
      bits_d[i_op.num] = 1'b1;
    end else if (i_op.clr_num) begin
      bits_d[i_op.num] = 1'b0;
    end
    // Inactive sources drop their bit
    bits_d    = bits_d & i_active;
    bits_d[0] = 1'b0;
  end

  always_ff @(posedge i_clk or negedge ni_rst) begin
    if (!ni_rst) begin
      o_bits <= '0;
    end else begin
      o_bits <= bits_d;
    end
  end

endmodule

//--- source/aplic_source_cfg.sv
// sourcecfg storage with M-to-S delegation, giving the owner and active vectors
`timescale 1ns/100ps
`include "aplic_consts.svh"

module aplic_source_cfg (
  input  logic                                      i_clk,
  input  logic                                      ni_rst,
  input  logic                                      i_we,
  input  aplic_pkg::domain_e                        i_domain,
  input  logic [4:0]                                i_index,
  input  logic [31:0]                               i_data,
  output aplic_pkg::sourcecfg_u [`APLIC_NR_SRC-1:0] o_srccfg,
  output aplic_pkg::src_vec_t                       o_owner,
  output aplic_pkg::src_vec_t                       o_active
);
  import aplic_pkg::*;

  sourcecfg_u wr_cfg;
  sourcecfg_u new_cfg;
  logic       may_write;

  assign wr_cfg = i_data[`APLIC_SRC_D:0];

  // S only touches sources delegated to it
  assign may_write = (i_domain == DOMAIN_M) || o_owner[i_index];

  // Word kept in storage, D set stores zero
  always_comb begin
    new_cfg = '0;
    // Reserved modes 2 and 3 become inactive
    if (!wr_cfg.dlg.d && (wr_cfg.ndl.sm[2:1] != 2'b01)) begin
      new_cfg.ndl.sm = wr_cfg.ndl.sm;
    end
  end

  always_ff @(posedge i_clk or negedge ni_rst) begin
    if (!ni_rst) begin
      o_srccfg <= '0;
      o_owner  <= '0;
    end else if (i_we && (i_index != 5'd0) && may_write) begin
      o_srccfg[i_index] <= new_cfg;
      // Only M moves a source between domains
      if (i_domain == DOMAIN_M) begin
        o_owner[i_index] <= wr_cfg.dlg.d;
      end
    end
  end

  always_comb begin
    o_active = '0;
    for (int j = 1; j < `APLIC_NR_SRC; j++) begin
      o_active[j] = o_srccfg[j].ndl.sm != 3'd0;
    end
  end

endmodule

//--- source/aplic_target.sv
// Per-source target registers, normalized by the delivery mode of the owning domain
`timescale 1ns/100ps
`include "aplic_consts.svh"

module aplic_target (
  input  logic                           i_clk,
  input  logic                           ni_rst,
  input  logic                           i_we,
  input  aplic_pkg::domain_e             i_domain,
  input  logic [4:0]                     i_index,
  input  logic [31:0]                    i_data,
  input  aplic_pkg::src_vec_t            i_owner,
  input  aplic_pkg::src_vec_t            i_active,
  input  logic [1:0]                     i_dm,
  output logic [`APLIC_NR_SRC-1:0][31:0] o_target
);
  import aplic_pkg::*;

  logic        owned;
  logic [31:0] norm;

  assign owned = i_owner[i_index] == (i_domain == DOMAIN_S);

  always_comb begin
    if (i_dm[i_domain]) begin
      // MSI layout, bit 11 reserved
      norm = {i_data[31:12], 1'b0, i_data[10:0]};
    end else begin
      // Direct layout: hart index and nonzero priority
      norm = {i_data[31:18], 10'b0, i_data[7:0]};
      if (i_data[7:0] == 8'h00) begin
        norm[7:0] = 8'h01;
      end
    end
  end

  always_ff @(posedge i_clk or negedge ni_rst) begin
    if (!ni_rst) begin
      o_target <= '0;
    end else if (i_we && owned && i_active[i_index]) begin
      o_target[i_index] <= norm;
    end
  end

endmodule

//--- source/aplic_reg_access.sv
// Address decode, domaincfg storage and per-domain read views of the APLIC register window
`timescale 1ns/100ps
`include "aplic_consts.svh"

module aplic_reg_access (
  input  logic                                        i_clk,
  input  logic                                        ni_rst,
  input  aplic_pkg::reg_req_t                         i_req,
  input  aplic_pkg::sourcecfg_u [`APLIC_NR_SRC-1:0]   i_srccfg,
  input  aplic_pkg::src_vec_t                         i_owner,
  input  aplic_pkg::src_vec_t                         i_ie,
  input  aplic_pkg::src_vec_t                         i_ip,
  input  logic [`APLIC_NR_SRC-1:0][31:0]              i_target,
  output logic [31:0]                                 o_rdata,
  output aplic_pkg::domain_e                          o_wr_domain,
  output logic                                        o_srccfg_we,
  output logic                                        o_target_we,
  output logic [4:0]                                  o_wr_index,
  output logic [31:0]                                 o_wr_data,
  output aplic_pkg::bitvec_op_t                       o_ie_op,
  output aplic_pkg::bitvec_op_t                       o_ip_op,
  output logic [1:0]                                  o_dm,
  output logic [1:0]                                  o_domain_ie
);
  import aplic_pkg::*;

  logic [`APLIC_ADDR_W-1:0] word_adr;
  logic [`APLIC_ADDR_W-1:0] src_off;
  logic [`APLIC_ADDR_W-1:0] tgt_off;
  logic                     hit_src;
  logic                     hit_tgt;
  logic [4:0]               src_idx;
  logic                     wr;
  logic                     num_ok;
  src_vec_t                 own;
  sourcecfg_u               src_view;
  logic [31:0]              dcfg_rd;
  logic [31:0]              rd_word;
  logic [1:0]               ie_q;
  logic [1:0]               dm_q;
  logic [1:0]               be_q;

  // ==================================================================
  // Decode
  // ==================================================================
  assign word_adr = {i_req.adr[`APLIC_ADDR_W-1:2], 2'b00};
  assign src_off  = word_adr - `APLIC_SOURCECFG;
  assign tgt_off  = word_adr - `APLIC_TARGET;
  assign hit_src  = src_off < 14'((`APLIC_NR_SRC - 1) * 4);
  assign hit_tgt  = tgt_off < 14'((`APLIC_NR_SRC - 1) * 4);
  // Both arrays start 4 bytes past a 128-byte boundary
  // One entry index serves sourcecfg and target alike
  assign src_idx  = src_off[6:2] + 5'd1;
  assign wr       = i_req.valid && i_req.we;

  // Sources owned by the requesting domain
  // Source 0 is never owned
  assign own = ((i_req.domain == DOMAIN_S) ? i_owner : ~i_owner) & ~src_vec_t'(1);

  // Clear own[0] also drops number 0
  assign num_ok = own[i_req.dat[4:0]] && (i_req.dat[31:5] == '0);

  assign o_wr_domain = i_req.domain;
  assign o_wr_index  = src_idx;
  assign o_wr_data   = i_req.dat;
  assign o_srccfg_we = wr && hit_src;
  assign o_target_we = wr && hit_tgt;

  // Enable and pending updates
  always_comb begin
    o_ie_op          = '0;
    o_ie_op.set_word = wr && (word_adr == `APLIC_SETIE);
    o_ie_op.clr_word = wr && (word_adr == `APLIC_CLRIE);
    o_ie_op.set_num  = wr && num_ok && (word_adr == `APLIC_SETIENUM);
    o_ie_op.clr_num  = wr && num_ok && (word_adr == `APLIC_CLRIENUM);
    o_ie_op.data     = i_req.dat & own;
    o_ie_op.num      = i_req.dat[4:0];
    o_ip_op          = o_ie_op;
    o_ip_op.set_word = wr && (word_adr == `APLIC_SETIP);
    o_ip_op.clr_word = wr && (word_adr == `APLIC_IN_CLRIP);
    o_ip_op.set_num  = wr && num_ok && (word_adr == `APLIC_SETIPNUM);
    o_ip_op.clr_num  = wr && num_ok && (word_adr == `APLIC_CLRIPNUM);
  end

  // ==================================================================
  // domaincfg per domain
  // ==================================================================
  always_ff @(posedge i_clk or negedge ni_rst) begin
    if (!ni_rst) begin
      ie_q <= '0;
      dm_q <= '0;
      be_q <= '0;
    end else if (wr && (word_adr == `APLIC_DOMAINCFG)) begin
      ie_q[i_req.domain] <= i_req.dat[`APLIC_DCFG_IE];
      dm_q[i_req.domain] <= i_req.dat[`APLIC_DCFG_DM];
      be_q[i_req.domain] <= i_req.dat[`APLIC_DCFG_BE];
    end
  end

  assign o_dm        = dm_q;
  assign o_domain_ie = ie_q;

  always_comb begin
    dcfg_rd                 = `APLIC_DOMAINCFG_RESET;
    dcfg_rd[`APLIC_DCFG_IE] = ie_q[i_req.domain];
    dcfg_rd[`APLIC_DCFG_DM] = dm_q[i_req.domain];
    dcfg_rd[`APLIC_DCFG_BE] = be_q[i_req.domain];
  end

  // ==================================================================
  // Read views
  // ==================================================================
  always_comb begin
    src_view = i_srccfg[src_idx];
    if ((i_req.domain == DOMAIN_M) && i_owner[src_idx]) begin
      // Source delegated to S shows D with child index 0
      src_view       = '0;
      src_view.dlg.d = 1'b1;
    end else if ((i_req.domain == DOMAIN_S) && !i_owner[src_idx]) begin
      src_view = '0;
    end
  end

  always_comb begin
    rd_word = '0;
    case (word_adr)
      `APLIC_DOMAINCFG: rd_word = dcfg_rd;
      `APLIC_SETIP:     rd_word = i_ip & own;
      `APLIC_SETIE:     rd_word = i_ie & own;
      default: begin
        if (hit_src) begin
          rd_word = {21'b0, src_view};
        end else if (hit_tgt && own[src_idx]) begin
          rd_word = i_target[src_idx];
        end
      end
    endcase
  end

  assign o_rdata = (i_req.valid && !i_req.we) ? rd_word : '0;

endmodule

//--- source/aplic_domain_ctl.sv
// Top level of the two-domain APLIC register control, one Wishbone port per domain
`timescale 1ns/100ps
`include "aplic_consts.svh"

module aplic_domain_ctl (
  input  logic                i_clk,
  input  logic                ni_rst,
  input  aplic_pkg::wb_req_t  i_m_wb,
  input  aplic_pkg::wb_req_t  i_s_wb,
  output aplic_pkg::wb_rsp_t  o_m_wb,
  output aplic_pkg::wb_rsp_t  o_s_wb,
  output aplic_pkg::src_vec_t o_active,
  output aplic_pkg::src_vec_t o_owner,
  output aplic_pkg::src_vec_t o_ie,
  output aplic_pkg::src_vec_t o_ip,
  output logic [1:0]          o_domain_ie,
  output logic [1:0]          o_domain_dm
);
  import aplic_pkg::*;

  reg_req_t                         req;
  logic [31:0]                      rdata;
  domain_e                          wr_domain;
  logic                             srccfg_we;
  logic                             target_we;
  logic [4:0]                       wr_index;
  logic [31:0]                      wr_data;
  bitvec_op_t                       ie_op;
  bitvec_op_t                       ip_op;
  sourcecfg_u [`APLIC_NR_SRC-1:0]   srccfg;
  logic [`APLIC_NR_SRC-1:0][31:0]   target;

  aplic_wb_arbiter u_arbiter (
    .i_clk, .ni_rst, .i_m_wb, .i_s_wb,
    .i_rdata (rdata),
    .o_m_wb, .o_s_wb,
    .o_req   (req)
  );

  aplic_reg_access u_reg_access (
    .i_clk, .ni_rst,
    .i_req       (req),
    .i_srccfg    (srccfg),
    .i_owner     (o_owner),
    .i_ie        (o_ie),
    .i_ip        (o_ip),
    .i_target    (target),
    .o_rdata     (rdata),
    .o_wr_domain (wr_domain),
    .o_srccfg_we (srccfg_we),
    .o_target_we (target_we),
    .o_wr_index  (wr_index),
    .o_wr_data   (wr_data),
    .o_ie_op     (ie_op),
    .o_ip_op     (ip_op),
    .o_dm        (o_domain_dm),
    .o_domain_ie
  );

  aplic_source_cfg u_source_cfg (
    .i_clk, .ni_rst,
    .i_we     (srccfg_we),
    .i_domain (wr_domain),
    .i_index  (wr_index),
    .i_data   (wr_data),
    .o_srccfg (srccfg),
    .o_owner, .o_active
  );

  // Enable and pending share one vector implementation
  aplic_bit_vector u_enable (
    .i_clk, .ni_rst,
    .i_op     (ie_op),
    .i_active (o_active),
    .o_bits   (o_ie)
  );

  aplic_bit_vector u_pending (
    .i_clk, .ni_rst,
    .i_op     (ip_op),
    .i_active (o_active),
    .o_bits   (o_ip)
  );

  aplic_target u_target (
    .i_clk, .ni_rst,
    .i_we     (target_we),
    .i_domain (wr_domain),
    .i_index  (wr_index),
    .i_data   (wr_data),
    .i_owner  (o_owner),
    .i_active (o_active),
    .i_dm     (o_domain_dm),
    .o_target (target)
  );

endmodule

//--- verification/aplic_domain_ctl_assert.sv
// Bus protocol and vector checks, bound into every aplic_domain_ctl instance
`timescale 1ns/100ps

module aplic_domain_ctl_assert (
  input logic                i_clk,
  input logic                ni_rst,
  input aplic_pkg::wb_req_t  i_m_wb,
  input aplic_pkg::wb_req_t  i_s_wb,
  input aplic_pkg::wb_rsp_t  o_m_wb,
  input aplic_pkg::wb_rsp_t  o_s_wb,
  input aplic_pkg::src_vec_t o_ie,
  input aplic_pkg::src_vec_t o_ip
);
  import aplic_pkg::*;

  // Bus sampled mid-cycle, where ack and the master's stb overlap
  a_m_ack_req: assert property (@(negedge i_clk) disable iff (!ni_rst)
    o_m_wb.ack |-> (i_m_wb.cyc && i_m_wb.stb))
    else $error("M ack without an active request");

  a_s_ack_req: assert property (@(negedge i_clk) disable iff (!ni_rst)
    o_s_wb.ack |-> (i_s_wb.cyc && i_s_wb.stb))
    else $error("S ack without an active request");

  a_m_ack_gap: assert property (@(negedge i_clk) disable iff (!ni_rst)
    o_m_wb.ack |=> !o_m_wb.ack)
    else $error("M ack in two consecutive cycles");

  a_s_ack_gap: assert property (@(negedge i_clk) disable iff (!ni_rst)
    o_s_wb.ack |=> !o_s_wb.ack)
    else $error("S ack in two consecutive cycles");

  a_one_ack: assert property (@(negedge i_clk) disable iff (!ni_rst)
    !(o_m_wb.ack && o_s_wb.ack))
    else $error("Both ports acked in one cycle");

  // Source 0 never holds state
  a_bit0: assert property (@(posedge i_clk) disable iff (!ni_rst)
    !o_ie[0] && !o_ip[0])
    else $error("Bit 0 of enable or pending is set");

endmodule

bind aplic_domain_ctl aplic_domain_ctl_assert u_assert (.*);

//--- verification/aplic_domain_ctl_tb.sv
// Self-checking testbench of the APLIC domain control, run as top module aplic_domain_ctl_tb
`timescale 1ns/100ps
`include "aplic_consts.svh"

module aplic_domain_ctl_tb;
  import aplic_pkg::*;

  localparam int N_SEQ  = 700;
  localparam int N_RAND = 60;

  logic     i_clk;
  logic     ni_rst;
  wb_req_t  m_wb;
  wb_req_t  s_wb;
  wb_rsp_t  o_m_wb;
  wb_rsp_t  o_s_wb;
  src_vec_t o_active;
  src_vec_t o_owner;
  src_vec_t o_ie;
  src_vec_t o_ip;
  logic [1:0] o_domain_ie;
  logic [1:0] o_domain_dm;

  integer seed = 36052;
  int     quiet = 0;

  // Mirror of the register state
  // Owner bit set means owned by S
  src_vec_t    m_owner;
  logic [2:0]  m_sm [`APLIC_NR_SRC];
  src_vec_t    m_ie;
  src_vec_t    m_ip;
  logic [31:0] m_tgt [`APLIC_NR_SRC];
  logic [1:0]  m_dcfg_ie;
  logic [1:0]  m_dm;
  logic [1:0]  m_be;

  aplic_domain_ctl u_aplic_domain_ctl (
    .i_clk, .ni_rst,
    .i_m_wb (m_wb),
    .i_s_wb (s_wb),
    .o_m_wb, .o_s_wb, .o_active, .o_owner, .o_ie, .o_ip, .o_domain_ie, .o_domain_dm
  );

  always #4 i_clk = ~i_clk;

  // ====================================================================
  // Compare tasks
  // ====================================================================
  task automatic report_fail(input string msg);
    $display("FAIL @%0t: %s", $time, msg);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string msg);
    if (got !== exp) begin
      report_fail($sformatf("%s got %h expected %h", msg, got, exp));
    end
  endtask

  task automatic check_vec(input src_vec_t got, input src_vec_t exp, input string msg);
    if (got !== exp) begin
      report_fail($sformatf("%s got %h expected %h", msg, got, exp));
    end
  endtask

  task automatic check_rsp(input wb_rsp_t got, input wb_rsp_t exp, input string msg);
    if (got !== exp) begin
      report_fail($sformatf("%s got ack %b dat %h expected ack %b dat %h",
                            msg, got.ack, got.dat, exp.ack, exp.dat));
    end
  endtask

  // ====================================================================
  // Reference model
  // ====================================================================
  function automatic src_vec_t model_own(input domain_e dom);
    src_vec_t own;
    own = '0;
    for (int j = 1; j < `APLIC_NR_SRC; j++) begin
      own[j] = (dom == DOMAIN_S) ? m_owner[j] : !m_owner[j];
    end
    return own;
  endfunction

  function automatic src_vec_t model_active();
    src_vec_t a;
    a = '0;
    for (int j = 1; j < `APLIC_NR_SRC; j++) begin
      a[j] = m_sm[j] != 3'd0;
    end
    return a;
  endfunction

  function automatic logic [31:0] model_read(input domain_e dom, input logic [13:0] adr);
    src_vec_t    own;
    logic [31:0] w;
    int          j;
    own = model_own(dom);
    w = '0;
    if (adr == `APLIC_DOMAINCFG) begin
      w = `APLIC_DOMAINCFG_RESET;
      w[`APLIC_DCFG_IE] = m_dcfg_ie[dom];
      w[`APLIC_DCFG_DM] = m_dm[dom];
      w[`APLIC_DCFG_BE] = m_be[dom];
    end else if (adr == `APLIC_SETIE) begin
      w = m_ie & own;
    end else if (adr == `APLIC_SETIP) begin
      w = m_ip & own;
    end else if (adr >= `APLIC_SOURCECFG && adr < `APLIC_SOURCECFG + 14'd124) begin
      j = (adr - `APLIC_SOURCECFG) / 4 + 1;
      if (dom == DOMAIN_M) begin
        w = m_owner[j] ? 32'h400 : {29'b0, m_sm[j]};
      end else begin
        w = m_owner[j] ? {29'b0, m_sm[j]} : 32'h0;
      end
    end else if (adr >= `APLIC_TARGET && adr < `APLIC_TARGET + 14'd124) begin
      j = (adr - `APLIC_TARGET) / 4 + 1;
      w = own[j] ? m_tgt[j] : 32'h0;
    end
    return w;
  endfunction

  function automatic void model_write(input domain_e dom, input logic [13:0] adr,
                                      input logic [31:0] dat);
    src_vec_t own;
    src_vec_t act;
    logic [2:0] sm;
    logic num_ok;
    int j;
    own = model_own(dom);
    act = model_active();
    sm = (dat[2:0] == 3'd2 || dat[2:0] == 3'd3) ? 3'd0 : dat[2:0];
    num_ok = (dat[31:5] == '0) && own[dat[4:0]];
    if (adr == `APLIC_DOMAINCFG) begin
      m_dcfg_ie[dom] = dat[`APLIC_DCFG_IE];
      m_dm[dom] = dat[`APLIC_DCFG_DM];
      m_be[dom] = dat[`APLIC_DCFG_BE];
    end else if (adr >= `APLIC_SOURCECFG && adr < `APLIC_SOURCECFG + 14'd124) begin
      j = (adr - `APLIC_SOURCECFG) / 4 + 1;
      if (dom == DOMAIN_M) begin
        m_owner[j] = dat[`APLIC_SRC_D];
        m_sm[j] = dat[`APLIC_SRC_D] ? 3'd0 : sm;
      end else if (m_owner[j]) begin
        m_sm[j] = dat[`APLIC_SRC_D] ? 3'd0 : sm;
      end
    end else if (adr >= `APLIC_TARGET && adr < `APLIC_TARGET + 14'd124) begin
      j = (adr - `APLIC_TARGET) / 4 + 1;
      if (own[j] && act[j]) begin
        if (m_dm[dom]) begin
          m_tgt[j] = {dat[31:12], 1'b0, dat[10:0]};
        end else begin
          m_tgt[j] = {dat[31:18], 10'b0, (dat[7:0] == 8'h00) ? 8'h01 : dat[7:0]};
        end
      end
    end else begin
      case (adr)
        `APLIC_SETIE:    m_ie = m_ie | (dat & own);
        `APLIC_CLRIE:    m_ie = m_ie & ~(dat & own);
        `APLIC_SETIENUM: if (num_ok) m_ie[dat[4:0]] = 1'b1;
        `APLIC_CLRIENUM: if (num_ok) m_ie[dat[4:0]] = 1'b0;
        `APLIC_SETIP:    m_ip = m_ip | (dat & own);
        `APLIC_IN_CLRIP: m_ip = m_ip & ~(dat & own);
        `APLIC_SETIPNUM: if (num_ok) m_ip[dat[4:0]] = 1'b1;
        `APLIC_CLRIPNUM: if (num_ok) m_ip[dat[4:0]] = 1'b0;
        default: ;
      endcase
    end
    // Inactive sources hold no enable or pending bit
    act = model_active();
    m_ie = m_ie & act;
    m_ip = m_ip & act;
  endfunction

  // ====================================================================
  // Bus tasks
  // ====================================================================
  task automatic xfer(input domain_e dom, input logic we, input logic [13:0] adr,
                      input logic [31:0] dat);
    wb_req_t rq;
    wb_rsp_t rsp;
    wb_rsp_t exp;
    int      cnt;
    rq = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
    if (dom == DOMAIN_S) s_wb = rq;
    else m_wb = rq;
    cnt = 0;
    do begin
      @(negedge i_clk);
      rsp = (dom == DOMAIN_S) ? o_s_wb : o_m_wb;
      cnt++;
    end while (!rsp.ack && cnt < 40);
    if (!rsp.ack) begin
      report_fail($sformatf("No ack for transfer to offset %h", adr));
    end
    exp.ack = 1'b1;
    exp.dat = we ? 32'h0 : model_read(dom, adr);
    check_rsp(rsp, exp, $sformatf("%s %s offset %h", dom.name(), we ? "write" : "read", adr));
    if (we) model_write(dom, adr, dat);
    if (dom == DOMAIN_S) s_wb = '0;
    else m_wb = '0;
    @(negedge i_clk);
  endtask

  task automatic wb_write(input domain_e dom, input logic [13:0] adr, input logic [31:0] dat);
    xfer(dom, 1'b1, adr, dat);
  endtask

  task automatic wb_read(input domain_e dom, input logic [13:0] adr);
    xfer(dom, 1'b0, adr, 32'h0);
  endtask

  function automatic logic [13:0] src_adr(input int j);
    return `APLIC_SOURCECFG + 14'(4 * (j - 1));
  endfunction

  function automatic logic [13:0] tgt_adr(input int j);
    return `APLIC_TARGET + 14'(4 * (j - 1));
  endfunction

  // Group 0 enables, 1 pending, 2 mixed without sourcecfg writes
  task automatic rand_xfer(input domain_e dom, input int group);
    logic [31:0] r;
    logic [31:0] dat;
    logic [13:0] adr;
    logic [4:0]  j;
    int          k;
    r = $random(seed);
    dat = $random(seed);
    j = (r[8:4] == 5'd0) ? 5'd1 : r[8:4];
    k = (group == 2) ? (r[3:0] % 12) : (group * 4 + r[1:0]);
    case (k)
      0: adr = `APLIC_SETIE;
      1: adr = `APLIC_CLRIE;
      2: adr = `APLIC_SETIENUM;
      3: adr = `APLIC_CLRIENUM;
      4: adr = `APLIC_SETIP;
      5: adr = `APLIC_IN_CLRIP;
      6: adr = `APLIC_SETIPNUM;
      7: adr = `APLIC_CLRIPNUM;
      8, 9, 10: adr = tgt_adr(j);
      default: begin
        case (r[14:13])
          2'd0: adr = `APLIC_SETIE;
          2'd1: adr = `APLIC_SETIP;
          2'd2: adr = `APLIC_IN_CLRIP;
          default: adr = `APLIC_DOMAINCFG;
        endcase
      end
    endcase
    // Number registers mostly get a valid source number
    if (k < 8 && k % 4 >= 2 && r[12:10] != 3'd0) begin
      dat = {27'b0, r[20:16]};
    end
    if (k < 10) wb_write(dom, adr, dat);
    else wb_read(dom, adr);
  endtask

  task automatic idle(input int n);
    repeat (n) @(negedge i_clk);
  endtask

  // Output vectors compared once the state has settled
  always @(negedge i_clk) begin
    if (!ni_rst || o_m_wb.ack || o_s_wb.ack) quiet = 0;
    else if (quiet < 3) quiet++;
    if (quiet >= 2) begin
      check_vec(o_owner, m_owner, "o_owner");
      check_vec(o_active, model_active(), "o_active");
      check_vec(o_ie, m_ie, "o_ie");
      check_vec(o_ip, m_ip, "o_ip");
      check_word({30'b0, o_domain_ie}, {30'b0, m_dcfg_ie}, "o_domain_ie");
      check_word({30'b0, o_domain_dm}, {30'b0, m_dm}, "o_domain_dm");
    end
  end

  initial begin
    #(40 * 8 * (N_SEQ + 2 * N_RAND));
    $display("Timeout: the test did not finish in the expected time");
    $display("RESULT: FAIL");
    $fatal(1);
  end

  // ====================================================================
  // Test sequence
  // ====================================================================
  initial begin
    i_clk = 1'b0;
    ni_rst = 1'b0;
    m_wb = '0;
    s_wb = '0;
    m_owner = '0;
    m_ie = '0;
    m_ip = '0;
    m_dcfg_ie = '0;
    m_dm = '0;
    m_be = '0;
    for (int j = 0; j < `APLIC_NR_SRC; j++) begin
      m_sm[j] = '0;
      m_tgt[j] = '0;
    end
    repeat (3) @(negedge i_clk);
    ni_rst = 1'b1;
    idle(3);

    // Reset values
    for (int d = 0; d < 2; d++) begin
      wb_read(domain_e'(d), `APLIC_DOMAINCFG);
      wb_read(domain_e'(d), `APLIC_SETIE);
      wb_read(domain_e'(d), `APLIC_SETIP);
    end
    idle(3);

    // Delegation from M, then S configures its sources
    for (int j = 1; j < `APLIC_NR_SRC; j++) begin
      logic [31:0] dat;
      dat = $random(seed) & 32'h3FF;
      if ($random(seed) % 4 == 0) dat[`APLIC_SRC_D] = 1'b1;
      wb_write(DOMAIN_M, src_adr(j), dat);
    end
    for (int j = 1; j < `APLIC_NR_SRC; j++) begin
      logic [31:0] dat;
      dat = $random(seed) & 32'h3FF;
      if ($random(seed) % 6 == 0) dat[`APLIC_SRC_D] = 1'b1;
      wb_write(DOMAIN_S, src_adr(j), dat);
    end
    for (int j = 1; j < `APLIC_NR_SRC; j++) begin
      wb_read(DOMAIN_M, src_adr(j));
      wb_read(DOMAIN_S, src_adr(j));
    end
    idle(3);

    // Enables, then pending
    for (int g = 0; g < 2; g++) begin
      for (int i = 0; i < 40; i++) begin
        domain_e dom;
        dom = domain_e'($random(seed) & 1);
        rand_xfer(dom, g);
        wb_read(dom, (g == 0) ? `APLIC_SETIE : `APLIC_SETIP);
        wb_read(dom, (g == 0) ? `APLIC_CLRIE : `APLIC_IN_CLRIP);
      end
      idle(3);
    end

    // Target normalization under both delivery modes
    for (int dm = 0; dm < 2; dm++) begin
      wb_write(DOMAIN_M, `APLIC_DOMAINCFG, ($random(seed) & ~32'h4) | (dm << 2));
      wb_write(DOMAIN_S, `APLIC_DOMAINCFG, ($random(seed) & ~32'h4) | ((1 - dm) << 2));
      for (int j = 1; j < `APLIC_NR_SRC; j++) begin
        wb_write(DOMAIN_M, tgt_adr(j), $random(seed));
        wb_write(DOMAIN_S, tgt_adr(j), $random(seed));
      end
      for (int j = 1; j < `APLIC_NR_SRC; j++) begin
        wb_read(DOMAIN_M, tgt_adr(j));
        wb_read(DOMAIN_S, tgt_adr(j));
      end
      idle(3);
    end

    // Both ports at once
    fork
      for (int i = 0; i < N_RAND; i++) rand_xfer(DOMAIN_M, 2);
      for (int i = 0; i < N_RAND; i++) rand_xfer(DOMAIN_S, 2);
    join
    idle(4);

    // Final state sweep
    for (int j = 1; j < `APLIC_NR_SRC; j++) begin
      wb_read(DOMAIN_M, tgt_adr(j));
      wb_read(DOMAIN_S, src_adr(j));
    end
    idle(3);

    $display("RESULT: PASS");
    $finish;
  end

endmodule

//--- build.f
+incdir+source
source/aplic_pkg.sv
source/aplic_wb_arbiter.sv
source/aplic_bit_vector.sv
source/aplic_source_cfg.sv
source/aplic_target.sv
source/aplic_reg_access.sv
source/aplic_domain_ctl.sv
verification/aplic_domain_ctl_assert.sv
verification/aplic_domain_ctl_tb.sv

//--- Bender.yml
package:
  name: aplic_domain_ctl

sources:
  - include_dirs:
      - source
    files:
      - source/aplic_pkg.sv
      - source/aplic_wb_arbiter.sv
      - source/aplic_bit_vector.sv
      - source/aplic_source_cfg.sv
      - source/aplic_target.sv
      - source/aplic_reg_access.sv
      - source/aplic_domain_ctl.sv
  - target: test
    include_dirs:
      - source
    files:
      - verification/aplic_domain_ctl_assert.sv
      - verification/aplic_domain_ctl_tb.sv
